// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // Datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Instruction word and field widths
    localparam int ILEN     = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // Major opcodes of the supported subset
    localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;  // lw
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;  // addi, slti, xori, ori, andi
    localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;  // sw
    localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;  // add, sub, slt, xor, or, and
    localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;  // beq

    // funct3 of the ALU instructions
    localparam logic [FUNCT3_W-1:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] FUNCT3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] FUNCT3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] FUNCT3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] FUNCT3_AND     = 3'b111;

    // funct7 of the register-register group
    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;  // add and the logic ops
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000;  // sub

endpackage

// File: source/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // Immediate format
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10
    } imm_src_e;

    // ALU operation class from the main decoder
    typedef enum logic [1:0] {
        ALU_OP_ADD   = 2'b00,  // Address add for lw/sw
        ALU_OP_SUB   = 2'b01,  // Compare for beq
        ALU_OP_FUNCT = 2'b10   // Look at funct3/funct7
    } alu_op_e;

    // ALU function code
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLT = 3'b101
    } alu_fn_e;

    // Control word, 9 bits
    typedef struct packed {
        logic     reg_wr_en;
        logic     mem_wr_en;
        imm_src_e imm_src;
        logic     alu_src;     // 1 selects the immediate
        logic     branch;
        logic     result_src;  // 1 selects load data
        alu_op_e  alu_op;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{
        reg_wr_en:  1'b0,
        mem_wr_en:  1'b0,
        imm_src:    IMM_I,
        alu_src:    1'b0,
        branch:     1'b0,
        result_src: 1'b0,
        alu_op:     ALU_OP_ADD
    };

endpackage

// File: source/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
    input  logic [rv_isa_pkg::OPCODE_W-1:0] opcode_i,  // Instruction bits 6:0
    output rv_ctrl_pkg::ctrl_t              ctrl_o
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    always_comb begin
        // Unknown opcodes fall through as a no-op
        ctrl_o = CTRL_NOP;

        case (opcode_i)
            OPC_LOAD: begin
                ctrl_o.reg_wr_en  = 1'b1;
                ctrl_o.imm_src    = IMM_I;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = 1'b1;  // Write back load data
                ctrl_o.alu_op     = ALU_OP_ADD;
            end

            OPC_OP_IMM: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.imm_src   = IMM_I;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_op    = ALU_OP_FUNCT;
            end

            OPC_STORE: begin
                ctrl_o.mem_wr_en = 1'b1;
                ctrl_o.imm_src   = IMM_S;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_op    = ALU_OP_ADD;  // rs1 + offset
            end

            OPC_OP: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.alu_src   = 1'b0;
                ctrl_o.alu_op    = ALU_OP_FUNCT;
            end

            // beq compares rs1 and rs2 by subtraction
            OPC_BRANCH: begin
                ctrl_o.imm_src = IMM_B;
                ctrl_o.alu_src = 1'b0;
                ctrl_o.branch  = 1'b1;
                ctrl_o.alu_op  = ALU_OP_SUB;
            end

            default: begin
                ctrl_o = CTRL_NOP;
            end
        endcase
    end

endmodule

// File: source/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
    input  rv_ctrl_pkg::alu_op_e            alu_op_i,
    input  logic [rv_isa_pkg::FUNCT3_W-1:0] funct3_i,
    input  logic                            funct7_b5_i,  // Instruction bit 30
    input  logic                            op_b5_i,      // Set for R-type, clear for I-type
    output rv_ctrl_pkg::alu_fn_e            alu_fn_o
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic is_sub;

    // Bit 30 of addi is immediate data, so the opcode must say R-type too
    assign is_sub = funct7_b5_i & op_b5_i;

    always_comb begin
        alu_fn_o = ALU_ADD;

        case (alu_op_i)
            ALU_OP_ADD: alu_fn_o = ALU_ADD;
            ALU_OP_SUB: alu_fn_o = ALU_SUB;
            ALU_OP_FUNCT: begin
                case (funct3_i)
                    FUNCT3_ADD_SUB: alu_fn_o = is_sub ? ALU_SUB : ALU_ADD;
                    FUNCT3_SLT:     alu_fn_o = ALU_SLT;
                    FUNCT3_XOR:     alu_fn_o = ALU_XOR;
                    FUNCT3_OR:      alu_fn_o = ALU_OR;
                    FUNCT3_AND:     alu_fn_o = ALU_AND;
                    default:        alu_fn_o = ALU_ADD;  // Shifts and sltu not in the subset
                endcase
            end
            default: alu_fn_o = ALU_ADD;
        endcase
    end

endmodule

// File: source/imm_extend.sv
`timescale 1ns/1ps

module imm_extend (
    input  logic [rv_isa_pkg::ILEN-1:0] instr_i,
    input  rv_ctrl_pkg::imm_src_e       imm_src_i,
    output logic [rv_isa_pkg::XLEN-1:0] imm_o
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic sign;

    assign sign = instr_i[31];  // Sign sits at bit 31 in every format

    always_comb begin
        case (imm_src_i)
            IMM_I: imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            // Branch offset in halfwords, bit 0 implied zero
            IMM_B: imm_o = {{(XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rv_isa_pkg::XLEN-1:0] a_i,
    input  logic [rv_isa_pkg::XLEN-1:0] b_i,
    input  rv_ctrl_pkg::alu_fn_e        fn_i,
    output logic [rv_isa_pkg::XLEN-1:0] result_o,
    output logic                        zero_o
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic lt_signed;

    assign lt_signed = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (fn_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, lt_signed};
            default: result_o = '0;
        endcase
    end

    // Equal operands under SUB give zero, used by beq
    assign zero_o = (result_o == '0);

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              we_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv_isa_pkg::XLEN-1:0]       wd_i,
    output logic [rv_isa_pkg::XLEN-1:0]       rd1_o,
    output logic [rv_isa_pkg::XLEN-1:0]       rd2_o
);

    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs_q [1:(2**REG_ADDR_W)-1];  // No storage for x0

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs_q[rd_i] <= wd_i;
        end
    end

    // Combinational reads
    assign rd1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// File: source/riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // Instruction port
    output logic [rv_isa_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_isa_pkg::ILEN-1:0] imem_instr_i,
    // Data port
    output logic [rv_isa_pkg::XLEN-1:0] dmem_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0] dmem_wdata_o,
    output logic                        dmem_we_o,
    input  logic [rv_isa_pkg::XLEN-1:0] dmem_rdata_i
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [XLEN-1:0]       pc_q;
    logic [XLEN-1:0]       pc_next;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       pc_target;
    logic                  take_branch;

    logic [OPCODE_W-1:0]   opcode;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [FUNCT3_W-1:0]   funct3;

    ctrl_t                 ctrl;
    alu_fn_e               alu_fn;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rd1, rd2;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_result;
    logic                  alu_zero;
    logic [XLEN-1:0]       result;
    logic                  reg_we;

    // Instruction fields
    assign opcode = imem_instr_i[6:0];
    assign rd     = imem_instr_i[11:7];
    assign funct3 = imem_instr_i[14:12];
    assign rs1    = imem_instr_i[19:15];
    assign rs2    = imem_instr_i[24:20];

    main_decoder main_decoder_i (
        .opcode_i (opcode),
        .ctrl_o   (ctrl)
    );

    alu_decoder alu_decoder_i (
        .alu_op_i    (ctrl.alu_op),
        .funct3_i    (funct3),
        .funct7_b5_i (imem_instr_i[30]),
        .op_b5_i     (opcode[5]),
        .alu_fn_o    (alu_fn)
    );

    imm_extend imm_extend_i (
        .instr_i   (imem_instr_i),
        .imm_src_i (ctrl.imm_src),
        .imm_o     (imm)
    );

    reg_file reg_file_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (reg_we),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (rd),
        .wd_i    (result),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    assign alu_b = ctrl.alu_src ? imm : rd2;  // Immediate or rs2

    alu alu_i (
        .a_i      (rd1),
        .b_i      (alu_b),
        .fn_i     (alu_fn),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    assign result = ctrl.result_src ? dmem_rdata_i : alu_result;

    // No writes of any kind while in reset
    assign reg_we    = ctrl.reg_wr_en & rst_n_i;
    assign dmem_we_o = ctrl.mem_wr_en & rst_n_i;

    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rd2;

    // Next PC
    assign pc_plus4    = pc_q + XLEN'(4);
    assign pc_target   = pc_q + imm;
    assign take_branch = ctrl.branch & alu_zero;  // beq only
    assign pc_next     = take_branch ? pc_target : pc_plus4;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign imem_addr_o = pc_q;

endmodule

// File: tb/riscv_checker.sv
`timescale 1ns/1ps

module riscv_checker #(
    parameter logic [31:0] HALT_ADDR = 32'h0,
    parameter int          DUMP_BASE = 32
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] imem_addr_i,
    input  logic [31:0] imem_instr_i,
    input  logic [31:0] dmem_addr_i,
    input  logic [31:0] dmem_wdata_i,
    input  logic        dmem_we_i,
    output logic        done_o,
    output logic [15:0] fail_cnt_o
);

    import rv_isa_pkg::*;

    localparam int T_RESET = 0;
    localparam int T_FLOW  = 1;
    localparam int T_STORE = 2;
    localparam int T_DUMP  = 3;
    localparam int T_UNK   = 4;

    logic [31:0] regs_m [32];
    logic [31:0] mem_m [64];   // Model data memory
    logic [31:0] seen_m [64];  // Words as the DUT wrote them
    logic [31:0] pc_m;
    int          errs [5] = '{default: 0};
    int          pc_test;      // Test charged with the next PC compare
    bit          running;

    function automatic string test_name(int t);
        case (t)
            T_RESET: return "reset";
            T_FLOW:  return "program_flow";
            T_STORE: return "store_traffic";
            T_DUMP:  return "register_dump";
            default: return "unknown_opcode";
        endcase
    endfunction

    function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        case (f3)
            FUNCT3_ADD_SUB: return alt ? a - b : a + b;
            FUNCT3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            FUNCT3_XOR:     return a ^ b;
            FUNCT3_OR:      return a | b;
            FUNCT3_AND:     return a & b;
            default:        return '0;
        endcase
    endfunction

    task automatic check_value(int t, string what, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h actual %h", test_name(t), what, exp, act);
            errs[t]++;
        end
    endtask

    // One instruction of the reference model
    task automatic step_model();
        logic [31:0] ins, a, b, imm_i, imm_s, imm_b;
        logic        taken;
        ins     = imem_instr_i;
        a       = regs_m[ins[19:15]];
        b       = regs_m[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        taken   = 1'b0;
        pc_test = T_FLOW;
        case (ins[6:0])
            OPC_LOAD:   regs_m[ins[11:7]] = mem_m[6'((a + imm_i) >> 2)];
            OPC_OP_IMM: regs_m[ins[11:7]] = alu_model(ins[14:12], 1'b0, a, imm_i);
            OPC_OP:     regs_m[ins[11:7]] = alu_model(ins[14:12], ins[30], a, b);
            OPC_STORE: begin
                mem_m[6'((a + imm_s) >> 2)] = b;
                check_value(T_STORE, "dmem_addr", a + imm_s, dmem_addr_i);
                check_value(T_STORE, "dmem_wdata", b, dmem_wdata_i);
            end
            OPC_BRANCH: taken = (a == b);
            default:    pc_test = T_UNK;  // No-op, only the PC moves
        endcase
        regs_m[0] = '0;
        check_value((pc_test == T_UNK) ? T_UNK : T_STORE, "dmem_we",
                    32'(ins[6:0] == OPC_STORE), {31'b0, dmem_we_i});
        pc_m = taken ? pc_m + imm_b : pc_m + 4;
    endtask

    task automatic finish_run();
        int failed;
        failed = 0;
        for (int r = 1; r < 32; r++) begin
            check_value(T_DUMP, $sformatf("x%0d", r), regs_m[r], seen_m[DUMP_BASE + r - 1]);
        end
        for (int t = 0; t < 5; t++) begin
            $display("%-15s %s (%0d errors)", test_name(t), (errs[t] == 0) ? "PASS" : "FAIL",
                     errs[t]);
            failed += (errs[t] != 0);
        end
        $display("%0d tests passed, %0d failed", 5 - failed, failed);
        fail_cnt_o = 16'(failed);
        done_o     = 1'b1;
    endtask

    initial begin
        done_o     = 1'b0;
        fail_cnt_o = '0;
        pc_m       = '0;
        pc_test    = T_FLOW;
        running    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_m[i]  = 32'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0000;  // Same fill as the RAM
            seen_m[i] = mem_m[i];
        end
    end

    // Sampled mid-cycle, away from the drive edge
    always @(negedge clk_i) begin
        if (dmem_we_i === 1'b1) begin
            seen_m[dmem_addr_i[7:2]] = dmem_wdata_i;
        end
        if (!rst_n_i) begin
            check_value(T_RESET, "imem_addr", '0, imem_addr_i);
            check_value(T_RESET, "dmem_we", '0, {31'b0, dmem_we_i});
            for (int i = 0; i < 32; i++) begin
                regs_m[i] = '0;
            end
            pc_m    = '0;
            running = 1'b0;
        end else if (!done_o) begin
            check_value(running ? pc_test : T_RESET, "imem_addr", pc_m, imem_addr_i);
            running = 1'b1;
            if (pc_m == HALT_ADDR) begin
                finish_run();
            end else begin
                step_model();
            end
        end
    end

endmodule

// File: tb/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core;

    import rv_isa_pkg::*;

    localparam int N_SEED     = 8;
    localparam int RAND_END   = N_SEED + 48;       // Index of the first dump store
    localparam int PROG_LEN   = RAND_END + 31 + 1;  // Dump of x1..x31, then the halt loop
    localparam int DUMP_BASE  = 32;                 // Dump words sit above the random data area
    localparam int MAX_CYCLES = 2 * PROG_LEN + 20;
    localparam logic [14:0] ALU_F3S  = {FUNCT3_AND, FUNCT3_OR, FUNCT3_XOR, FUNCT3_SLT,
                                        FUNCT3_ADD_SUB};
    // lui, jal, fence and system, all outside the subset
    localparam logic [27:0] BAD_OPCS = {7'b0110111, 7'b1101111, 7'b0001111, 7'b1110011};

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr, imem_instr, dmem_addr, dmem_wdata, dmem_rdata;
    logic        dmem_we;
    logic        done;
    logic [15:0] fail_cnt;
    int          cycles = 0;
    logic [31:0] rom [PROG_LEN];
    logic [31:0] ram [64];

    function automatic logic [31:0] enc_sw(logic [11:0] off, logic [4:0] rs2);
        return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], OPC_STORE};  // x0 base
    endfunction

    task automatic build_program();
        int unsigned sel;
        int unsigned k;
        logic [2:0]  f3;
        logic [12:0] boff;
        for (int i = 0; i < N_SEED; i++) begin
            rom[i] = {12'($urandom), 5'd0, FUNCT3_ADD_SUB, 5'(i + 1), OPC_OP_IMM};
        end
        for (int i = N_SEED; i < RAND_END; i++) begin
            sel  = $urandom % 16;
            f3   = ALU_F3S[3 * ($urandom % 5) +: 3];
            k    = 1 + $urandom % 4;
            boff = 13'(4 * ((i + k > RAND_END) ? RAND_END - i : k));  // Never past the dump start
            if (sel < 5) begin
                rom[i] = {12'($urandom), 5'($urandom), f3, 5'($urandom), OPC_OP_IMM};
            end else if (sel < 10) begin
                rom[i] = {(f3 == FUNCT3_ADD_SUB && $urandom % 2 == 1) ? FUNCT7_ALT : FUNCT7_BASE,
                          5'($urandom), 5'($urandom), f3, 5'($urandom), OPC_OP};
            end else if (sel < 12) begin
                rom[i] = {12'(4 * ($urandom % 32)), 5'd0, 3'b010, 5'($urandom), OPC_LOAD};
            end else if (sel < 14) begin
                rom[i] = enc_sw(12'(4 * ($urandom % 32)), 5'($urandom));
            end else if (sel < 15) begin
                // Compare among x0..x3 so that some branches are taken
                rom[i] = {boff[12], boff[10:5], 5'($urandom % 4), 5'($urandom % 4), 3'b000,
                          boff[4:1], boff[11], OPC_BRANCH};
            end else begin
                rom[i] = {25'($urandom), BAD_OPCS[7 * ($urandom % 4) +: 7]};
            end
        end
        for (int r = 1; r < 32; r++) begin
            rom[RAND_END + r - 1] = enc_sw(12'(4 * (DUMP_BASE + r - 1)), 5'(r));
        end
        rom[PROG_LEN - 1] = 32'h0000_0063;  // beq x0, x0, 0
    endtask

    // Both memories answer in the same cycle
    // During reset the bus carries a store, which the core must not perform
    assign imem_instr = !rst_n ? enc_sw(12'h0, 5'd0)
                      : (imem_addr[31:2] < PROG_LEN) ? rom[imem_addr[31:2]] : 32'h0;
    assign dmem_rdata = ram[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            ram[dmem_addr[7:2]] <= dmem_wdata;
        end
        cycles <= cycles + 1;
    end

    riscv_core riscv_core_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_instr_i (imem_instr),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata)
    );

    riscv_checker #(.HALT_ADDR(32'(4 * (PROG_LEN - 1))), .DUMP_BASE(DUMP_BASE)) riscv_checker_i (
        .clk_i (clk), .rst_n_i (rst_n), .imem_addr_i (imem_addr), .imem_instr_i (imem_instr),
        .dmem_addr_i (dmem_addr), .dmem_wdata_i (dmem_wdata), .dmem_we_i (dmem_we),
        .done_o (done), .fail_cnt_o (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'ha3c9599c));
        build_program();
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0000;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge clk);
        end
        if (!done) begin
            $display("timeout: halt address not reached");
            $display("TB FAILED");
        end else if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: riscv_core.f
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/main_decoder.sv
source/alu_decoder.sv
source/imm_extend.sv
source/alu.sv
source/reg_file.sv
source/riscv_core.sv
tb/riscv_checker.sv
tb/tb_riscv_core.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - source/rv_isa_pkg.sv
  - source/rv_ctrl_pkg.sv
  - source/main_decoder.sv
  - source/alu_decoder.sv
  - source/imm_extend.sv
  - source/alu.sv
  - source/reg_file.sv
  - source/riscv_core.sv
  - target: simulation
    files:
      - tb/riscv_checker.sv
      - tb/tb_riscv_core.sv
